//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // register number x0..x31
  typedef logic [4:0] reg_idx_t;

  // inst[6:0]
  typedef logic [6:0] opcode_t;

  // base opcode map, only the supported groups
  localparam opcode_t OP_R       = 7'b0110011;
  localparam opcode_t OP_I_ARITH = 7'b0010011;
  localparam opcode_t OP_I_LOAD  = 7'b0000011;
  localparam opcode_t OP_S       = 7'b0100011;
  localparam opcode_t OP_B       = 7'b1100011;
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_JAL     = 7'b1101111;
  localparam opcode_t OP_JALR    = 7'b1100111;

  // branch condition in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // addi x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;

  // alu operation, ADD is zero so a cleared bundle adds
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL
  } alu_op_e;

endpackage

//--- common/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // decoded controls, all zero is a bubble
  typedef struct packed {
    logic                reg_write;
    logic                mem_to_reg;
    logic                mem_write;
    logic                mem_read;
    logic                alu_src;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    logic                is_lui;
    rv_isa_pkg::alu_op_e alu_op;
  } ctrl_t;

  // decode to execute
  typedef struct packed {
    ctrl_t                ctrl;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    op_a;
    rv_isa_pkg::word_t    op_b;
    rv_isa_pkg::word_t    store_data;
    rv_isa_pkg::reg_idx_t rd;
    logic [2:0]           funct3;
    rv_isa_pkg::word_t    imm_b;
    rv_isa_pkg::word_t    imm_j;
  } id_ex_t;

  // execute to memory
  // is_link marks jal/jalr, whose result is the link value
  typedef struct packed {
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 mem_write;
    logic                 mem_read;
    logic                 is_link;
    rv_isa_pkg::word_t    alu_result;
    rv_isa_pkg::word_t    store_data;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    link;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    logic                 reg_write;
    logic                 mem_to_reg;
    logic                 is_link;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    alu_result;
    rv_isa_pkg::word_t    load_data;
    rv_isa_pkg::word_t    link;
  } mem_wb_t;

  // operand source for decode
  typedef enum logic [2:0] {
    FWD_RF,
    FWD_EX,
    FWD_MEM_ALU,
    FWD_MEM_LOAD,
    FWD_WB
  } fwd_sel_e;

endpackage

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  rv_isa_pkg::word_t  inst,
  output rv_pipe_pkg::ctrl_t ctrl,
  output rv_isa_pkg::word_t  imm_i,
  output rv_isa_pkg::word_t  imm_s,
  output rv_isa_pkg::word_t  imm_u,
  output rv_isa_pkg::word_t  imm_b,
  output rv_isa_pkg::word_t  imm_j
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // sign-extended immediates, every format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb
  begin
    // unknown opcode falls through as a no-op
    ctrl        = '0;
    ctrl.alu_op = rv_isa_pkg::ADD;
    case (opcode)
      rv_isa_pkg::OP_R:
      begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0100000_000: ctrl.alu_op = rv_isa_pkg::SUB;
          10'b0000000_111: ctrl.alu_op = rv_isa_pkg::AND;
          10'b0000000_110: ctrl.alu_op = rv_isa_pkg::OR;
          default:         ctrl.alu_op = rv_isa_pkg::ADD;
        endcase
      end
      rv_isa_pkg::OP_I_ARITH:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        case (funct3)
          3'b111:  ctrl.alu_op = rv_isa_pkg::AND;
          3'b110:  ctrl.alu_op = rv_isa_pkg::OR;
          3'b100:  ctrl.alu_op = rv_isa_pkg::XOR;
          3'b001:  ctrl.alu_op = rv_isa_pkg::SLL;
          default: ctrl.alu_op = rv_isa_pkg::ADD;
        endcase
      end
      // lw, address is rs1 + imm_i
      rv_isa_pkg::OP_I_LOAD:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      rv_isa_pkg::OP_S:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      // compare by subtraction, flags feed the branch check
      rv_isa_pkg::OP_B:
      begin
        ctrl.is_branch = 1'b1;
        ctrl.alu_op    = rv_isa_pkg::SUB;
      end
      rv_isa_pkg::OP_LUI:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_lui    = 1'b1;
      end
      rv_isa_pkg::OP_JAL:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
      end
      // target is rs1 + imm_i through the alu
      rv_isa_pkg::OP_JALR:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.is_jalr   = 1'b1;
      end
      default:
      begin
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t waddr,
  input  rv_isa_pkg::word_t    wdata,
  input  rv_isa_pkg::reg_idx_t raddr1,
  input  rv_isa_pkg::reg_idx_t raddr2,
  output rv_isa_pkg::word_t    rdata1,
  output rv_isa_pkg::word_t    rdata2
);

  // x1..x31, x0 has no storage
  rv_isa_pkg::word_t regs [1:31];
  logic              wr_en;

  assign wr_en = we && (waddr != 5'd0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 1; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[waddr] <= wdata;
    end
  end

  // same-cycle write shows up on the read port
  assign rdata1 = (raddr1 == 5'd0) ? '0 :
                  (wr_en && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 :
                  (wr_en && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  input  rv_isa_pkg::alu_op_e op,
  output rv_isa_pkg::word_t   result,
  output logic                flag_n,
  output logic                flag_z,
  output logic                flag_c,
  output logic                flag_v
);

  logic              is_sub;
  rv_isa_pkg::word_t b_in;
  logic [32:0]       sum;

  // one adder, subtract as a + ~b + 1
  assign is_sub = (op == rv_isa_pkg::SUB);
  assign b_in   = is_sub ? ~b : b;
  assign sum    = {1'b0, a} + {1'b0, b_in} + {32'b0, is_sub};

  always_comb
  begin
    case (op)
      rv_isa_pkg::ADD: result = sum[31:0];
      rv_isa_pkg::SUB: result = sum[31:0];
      rv_isa_pkg::AND: result = a & b;
      rv_isa_pkg::OR:  result = a | b;
      rv_isa_pkg::XOR: result = a ^ b;
      rv_isa_pkg::SLL: result = a << b[4:0];
      default:         result = sum[31:0];
    endcase
  end

  assign flag_n = result[31];
  assign flag_z = (result == '0);
  // on sub, carry out means a >= b unsigned
  assign flag_c = sum[32];
  // same-sign inputs giving a different-sign sum
  assign flag_v = (a[31] == b_in[31]) && (sum[31] != a[31]);

endmodule

//--- logic/rv_hazard_unit.sv
`timescale 1ns/1ps

module rv_hazard_unit (
  input  rv_isa_pkg::reg_idx_t  rs1,
  input  rv_isa_pkg::reg_idx_t  rs2,
  input  rv_isa_pkg::reg_idx_t  ex_rd,
  input  rv_isa_pkg::reg_idx_t  mem_rd,
  input  rv_isa_pkg::reg_idx_t  wb_rd,
  input  logic                  ex_reg_write,
  input  logic                  ex_mem_read,
  input  logic                  mem_reg_write,
  input  logic                  mem_mem_read,
  input  logic                  wb_reg_write,
  input  logic                  redirect,
  output rv_pipe_pkg::fwd_sel_e fwd_a,
  output rv_pipe_pkg::fwd_sel_e fwd_b,
  output logic                  stall,
  output logic                  flush
);

  logic load_use;

  // youngest writer of rs wins, x0 never forwards
  function automatic rv_pipe_pkg::fwd_sel_e pick_source(input rv_isa_pkg::reg_idx_t rs);
    if (rs == 5'd0)
      return rv_pipe_pkg::FWD_RF;
    // load in execute has no data yet, the stall covers it
    if (ex_reg_write && ex_rd == rs)
      return ex_mem_read ? rv_pipe_pkg::FWD_RF : rv_pipe_pkg::FWD_EX;
    if (mem_reg_write && mem_rd == rs)
      return mem_mem_read ? rv_pipe_pkg::FWD_MEM_LOAD : rv_pipe_pkg::FWD_MEM_ALU;
    if (wb_reg_write && wb_rd == rs)
      return rv_pipe_pkg::FWD_WB;
    return rv_pipe_pkg::FWD_RF;
  endfunction

  assign fwd_a = pick_source(rs1);
  assign fwd_b = pick_source(rs2);

  // load result arrives one cycle too late for execute forwarding
  assign load_use = ex_mem_read && ex_reg_write && (ex_rd != 5'd0) &&
                    ((ex_rd == rs1) || (ex_rd == rs2));

  // redirect squashes the dependent anyway
  assign flush = redirect;
  assign stall = load_use && !redirect;

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_pipe_pkg::id_ex_t stage,
  output rv_isa_pkg::word_t   alu_result,
  output logic                redirect,
  output rv_isa_pkg::word_t   target
);

  logic flag_n;
  logic flag_z;
  logic flag_c;
  logic flag_v;
  logic taken;

  rv_alu alu_i (
    .a      (stage.op_a),
    .b      (stage.op_b),
    .op     (stage.ctrl.alu_op),
    .result (alu_result),
    .flag_n (flag_n),
    .flag_z (flag_z),
    .flag_c (flag_c),
    .flag_v (flag_v)
  );

  // condition from the sub flags
  always_comb
  begin
    case (stage.funct3)
      rv_isa_pkg::F3_BEQ:  taken = flag_z;
      rv_isa_pkg::F3_BNE:  taken = !flag_z;
      rv_isa_pkg::F3_BLT:  taken = (flag_n != flag_v);
      rv_isa_pkg::F3_BGE:  taken = (flag_n == flag_v);
      rv_isa_pkg::F3_BLTU: taken = !flag_c;
      rv_isa_pkg::F3_BGEU: taken = flag_c;
      default:             taken = 1'b0;
    endcase
  end

  assign redirect = (stage.ctrl.is_branch && taken) || stage.ctrl.is_jal ||
                    stage.ctrl.is_jalr;

  // jalr drops bit 0 of rs1 + imm
  always_comb
  begin
    if (stage.ctrl.is_jalr)
      target = {alu_result[31:1], 1'b0};
    else if (stage.ctrl.is_jal)
      target = stage.pc + stage.imm_j;
    else
      target = stage.pc + stage.imm_b;
  end

endmodule

//--- core/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core #(
  parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              reset,
  output rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t inst,
  output logic              mem_write,
  output rv_isa_pkg::word_t mem_addr,
  output rv_isa_pkg::word_t mem_wdata,
  input  rv_isa_pkg::word_t mem_rdata
);

  // decode stage register
  rv_isa_pkg::word_t     id_inst;
  rv_isa_pkg::word_t     id_pc;
  rv_pipe_pkg::ctrl_t    id_ctrl;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_s;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_b;
  rv_isa_pkg::word_t     imm_j;
  rv_isa_pkg::word_t     rf_rdata1;
  rv_isa_pkg::word_t     rf_rdata2;
  rv_isa_pkg::word_t     rs1_val;
  rv_isa_pkg::word_t     rs2_val;
  rv_pipe_pkg::fwd_sel_e fwd_a;
  rv_pipe_pkg::fwd_sel_e fwd_b;
  logic                  stall;
  logic                  flush;

  // stage registers and their next values
  rv_pipe_pkg::id_ex_t   id_ex;
  rv_pipe_pkg::id_ex_t   id_ex_d;
  rv_pipe_pkg::ex_mem_t  ex_mem;
  rv_pipe_pkg::ex_mem_t  ex_mem_d;
  rv_pipe_pkg::mem_wb_t  mem_wb;
  rv_pipe_pkg::mem_wb_t  mem_wb_d;

  // execute, memory and writeback results
  rv_isa_pkg::word_t     alu_result;
  logic                  redirect;
  rv_isa_pkg::word_t     target;
  logic                  ex_is_link;
  rv_isa_pkg::word_t     ex_link;
  rv_isa_pkg::word_t     ex_value;
  rv_isa_pkg::word_t     mem_value;
  rv_isa_pkg::word_t     wb_data;

  // fetch, hold on stall, jump on redirect
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= RESET_PC;
    else if (flush)
      pc <= target;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_inst <= rv_isa_pkg::NOP_INST;
      id_pc   <= '0;
    end
    else if (flush)
    begin
      id_inst <= rv_isa_pkg::NOP_INST;
    end
    else if (!stall)
    begin
      id_inst <= inst;
      id_pc   <= pc;
    end
  end

  rv_decoder decoder_i (
    .inst  (id_inst),
    .ctrl  (id_ctrl),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_u (imm_u),
    .imm_b (imm_b),
    .imm_j (imm_j)
  );

  rv_regfile regfile_i (
    .clk    (clk),
    .reset  (reset),
    .we     (mem_wb.reg_write),
    .waddr  (mem_wb.rd),
    .wdata  (wb_data),
    .raddr1 (id_inst[19:15]),
    .raddr2 (id_inst[24:20]),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  rv_hazard_unit hazard_i (
    .rs1           (id_inst[19:15]),
    .rs2           (id_inst[24:20]),
    .ex_rd         (id_ex.rd),
    .mem_rd        (ex_mem.rd),
    .wb_rd         (mem_wb.rd),
    .ex_reg_write  (id_ex.ctrl.reg_write),
    .ex_mem_read   (id_ex.ctrl.mem_read),
    .mem_reg_write (ex_mem.reg_write),
    .mem_mem_read  (ex_mem.mem_read),
    .wb_reg_write  (mem_wb.reg_write),
    .redirect      (redirect),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .stall         (stall),
    .flush         (flush)
  );

  function automatic rv_isa_pkg::word_t fwd_mux(
    input rv_pipe_pkg::fwd_sel_e sel,
    input rv_isa_pkg::word_t     rf,
    input rv_isa_pkg::word_t     ex,
    input rv_isa_pkg::word_t     mem,
    input rv_isa_pkg::word_t     load,
    input rv_isa_pkg::word_t     wb
  );
    case (sel)
      rv_pipe_pkg::FWD_EX:       return ex;
      rv_pipe_pkg::FWD_MEM_ALU:  return mem;
      rv_pipe_pkg::FWD_MEM_LOAD: return load;
      rv_pipe_pkg::FWD_WB:       return wb;
      default:                   return rf;
    endcase
  endfunction

  assign rs1_val = fwd_mux(fwd_a, rf_rdata1, ex_value, mem_value, mem_rdata, wb_data);
  assign rs2_val = fwd_mux(fwd_b, rf_rdata2, ex_value, mem_value, mem_rdata, wb_data);

  // operand build in decode
  always_comb
  begin
    id_ex_d            = '0;
    id_ex_d.ctrl       = id_ctrl;
    id_ex_d.pc         = id_pc;
    id_ex_d.op_a       = id_ctrl.is_lui ? '0 : rs1_val;
    id_ex_d.store_data = rs2_val;
    id_ex_d.rd         = id_inst[11:7];
    id_ex_d.funct3     = id_inst[14:12];
    id_ex_d.imm_b      = imm_b;
    id_ex_d.imm_j      = imm_j;
    if (id_ctrl.alu_src && id_ctrl.is_lui)
      id_ex_d.op_b = imm_u;
    else if (id_ctrl.alu_src && id_ctrl.mem_write)
      id_ex_d.op_b = imm_s;
    else if (id_ctrl.alu_src)
      id_ex_d.op_b = imm_i;
    else
      id_ex_d.op_b = rs2_val;
  end

  // stall or flush sends a bubble into execute
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else if (flush || stall)
      id_ex <= '0;
    else
      id_ex <= id_ex_d;
  end

  rv_execute execute_i (
    .stage      (id_ex),
    .alu_result (alu_result),
    .redirect   (redirect),
    .target     (target)
  );

  // jumps write the link, not the alu sum
  assign ex_is_link = id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr;
  assign ex_link    = id_ex.pc + 32'd4;
  assign ex_value   = ex_is_link ? ex_link : alu_result;

  always_comb
  begin
    ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
    ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
    ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
    ex_mem_d.is_link    = ex_is_link;
    ex_mem_d.alu_result = alu_result;
    ex_mem_d.store_data = id_ex.store_data;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.link       = ex_link;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
      ex_mem <= ex_mem_d;
  end

  // memory ports
  assign mem_write = ex_mem.mem_write;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_value = ex_mem.is_link ? ex_mem.link : ex_mem.alu_result;

  always_comb
  begin
    mem_wb_d.reg_write  = ex_mem.reg_write;
    mem_wb_d.mem_to_reg = ex_mem.mem_to_reg;
    mem_wb_d.is_link    = ex_mem.is_link;
    mem_wb_d.rd         = ex_mem.rd;
    mem_wb_d.alu_result = ex_mem.alu_result;
    mem_wb_d.load_data  = mem_rdata;
    mem_wb_d.link       = ex_mem.link;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
      mem_wb <= mem_wb_d;
  end

  // writeback select
  assign wb_data = mem_wb.is_link    ? mem_wb.link :
                   mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

//--- verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one word = 32 steps, one bit per step
function automatic logic [31:0] lfsr_word();
  logic [31:0] w;
  w = '0;
  for (int i = 0; i < 32; i++)
  begin
    lfsr_state = lfsr_step(lfsr_state);
    w = {w[30:0], lfsr_state[0]};
  end
  return w;
endfunction

// instruction encoders, field order as in the ISA manual
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

// sw only
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

// lui
function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

`endif

//--- verif/tb_rv32i_core.sv
`timescale 1ns/1ps

module tb_rv32i_core;

  logic [31:0] lfsr_state;

  `include "tb_program.svh"

  localparam logic [6:0] OPI = 7'b0010011;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  // word memories, index by address bits 9:2
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic        exp_valid [256];
  logic [31:0] exp_data [256];
  logic        seen [256];
  logic [31:0] opnd [5];

  int          loc;
  int          error_count;
  int          test_start_errors;
  int          pass_count;
  int          fail_count;
  int          cycles;
  int          missing;
  logic [5:0]  done_mask;
  logic        marker_hit;
  logic [31:0] marker_value;
  string       test_name [1:5];

  rv32i_core #(
    .RESET_PC (32'h0000_0000)
  ) dut_i (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  always #20 clk = ~clk;

  assign inst      = imem[pc[9:2]];
  assign mem_rdata = dmem[mem_addr[9:2]];

  // store lands at the edge, markers flagged for the next falling edge
  always @(posedge clk)
  begin
    marker_hit <= 1'b0;
    if (mem_write)
    begin
      dmem[mem_addr[9:2]] <= mem_wdata;
      seen[mem_addr[9:2]] <= 1'b1;
      if (mem_addr >= 32'h200 && mem_addr < 32'h218)
      begin
        marker_hit   <= 1'b1;
        marker_value <= mem_wdata;
      end
    end
  end

  always @(negedge clk)
  begin
    if (marker_hit)
      finish_test(marker_value[2:0]);
  end

  a_reset: assert property (@(posedge clk) reset |-> (pc == 32'h0 && !mem_write))
    else
    begin
      error_count++;
      $display("pc or mem_write wrong while reset is held");
    end

  // first fetch at the reset pc, then the next word
  a_after_reset: assert property (@(posedge clk)
    $fell(reset) |=> ($past(pc) == 32'h0 && pc == 32'h4))
    else
    begin
      error_count++;
      $display("pc did not start from the reset pc after reset");
    end

  // a jalr target keeps bit 0 out of pc
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else
    begin
      error_count++;
      $display("pc %h is not word aligned", $sampled(pc));
    end

  // flushed slots use unlisted poison addresses
  a_listed: assert property (@(posedge clk) disable iff (reset)
    mem_write |-> (mem_addr < 32'h400 && exp_valid[mem_addr[9:2]]))
    else
    begin
      error_count++;
      $display("store to unlisted address %h reached memory", $sampled(mem_addr));
    end

  a_data: assert property (@(posedge clk) disable iff (reset)
    (mem_write && mem_addr < 32'h400 && exp_valid[mem_addr[9:2]]) |->
    mem_wdata == exp_data[mem_addr[9:2]])
    else
    begin
      error_count++;
      $display("MISMATCH mem_wdata at %h: got %h expected %h", $sampled(mem_addr),
               $sampled(mem_wdata), exp_data[$sampled(mem_addr[9:2])]);
    end

  task automatic finish_test(input logic [2:0] t);
    int errs;
    errs = error_count - test_start_errors;
    test_start_errors = error_count;
    done_mask[t] = 1'b1;
    if (errs == 0)
    begin
      pass_count++;
      $display("test %0d %s: ok", t, test_name[t]);
    end
    else
    begin
      fail_count++;
      $display("test %0d %s: %0d errors", t, test_name[t], errs);
    end
  endtask

  task automatic emit(input logic [31:0] w);
    imem[loc] = w;
    loc++;
  endtask

  task automatic expect_store(input logic [11:0] addr, input logic [31:0] data);
    exp_valid[addr[9:2]] = 1'b1;
    exp_data[addr[9:2]]  = data;
  endtask

  task automatic store_check(input logic [4:0] rs2, input logic [11:0] addr,
                             input logic [31:0] data);
    emit(enc_s(addr, rs2, 5'd0));
    expect_store(addr, data);
  endtask

  // marker store, data is the test number
  task automatic mark(input logic [11:0] t);
    emit(enc_i(t, 5'd0, 3'b000, 5'd15, OPI));
    store_check(5'd15, 12'h200 + (t << 2), {20'b0, t});
  endtask

  // branch outcome straight from the ISA comparison
  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    logic [2:0]  f3_list [6];
    logic [2:0]  f3;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic        tk;
    logic [31:0] here;
    logic [11:0] slot;
    a = opnd[0];
    b = opnd[1];
    s = a + b;
    f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // x1..x4 from data words 0..3
    for (int i = 1; i < 5; i++)
      emit(enc_i(12'(4 * (i - 1)), 5'd0, 3'b010, 5'(i), 7'b0000011));
    // arithmetic, each result stored right behind its producer
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    store_check(5'd5, 12'h100, a + b);
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
    store_check(5'd6, 12'h104, a - b);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
    store_check(5'd7, 12'h108, a & b);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
    store_check(5'd8, 12'h10c, a | b);
    emit(enc_i(12'hf85, 5'd1, 3'b000, 5'd9, OPI));
    store_check(5'd9, 12'h110, a + 32'hffff_ff85);
    emit(enc_i(12'h5a5, 5'd1, 3'b111, 5'd10, OPI));
    store_check(5'd10, 12'h114, a & 32'h0000_05a5);
    emit(enc_i(12'hf00, 5'd2, 3'b110, 5'd11, OPI));
    store_check(5'd11, 12'h118, b | 32'hffff_ff00);
    emit(enc_i(12'h7ff, 5'd2, 3'b100, 5'd12, OPI));
    store_check(5'd12, 12'h11c, b ^ 32'h0000_07ff);
    emit(enc_i(12'd7, 5'd1, 3'b001, 5'd13, OPI));
    store_check(5'd13, 12'h120, a << 7);
    emit(enc_u(20'habcde, 5'd14));
    store_check(5'd14, 12'h124, 32'habcd_e000);
    mark(12'd1);
    // x16 consumed at distance 1, 2 and 3
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd16));
    emit(enc_r(7'h00, 5'd3, 5'd16, 3'b000, 5'd17));
    emit(enc_r(7'h00, 5'd4, 5'd16, 3'b000, 5'd18));
    emit(enc_r(7'h00, 5'd1, 5'd16, 3'b000, 5'd19));
    store_check(5'd17, 12'h128, s + opnd[2]);
    store_check(5'd18, 12'h12c, s + opnd[3]);
    store_check(5'd19, 12'h130, s + a);
    mark(12'd2);
    // load then dependent add
    emit(enc_i(12'd16, 5'd0, 3'b010, 5'd21, 7'b0000011));
    emit(enc_r(7'h00, 5'd1, 5'd21, 3'b000, 5'd22));
    store_check(5'd22, 12'h134, opnd[4] + a);
    mark(12'd3);
    // each branch type twice, once per outcome
    for (int j = 0; j < 12; j++)
    begin
      f3 = f3_list[j / 2];
      r1 = (j % 2 == 1) ? 5'd2 : 5'd1;
      if (f3 == 3'b000 || f3 == 3'b001)
        r2 = 5'd2;
      else
        r2 = (j % 2 == 1) ? 5'd1 : 5'd2;
      tk = branch_taken(f3, (r1 == 5'd1) ? a : b, (r2 == 5'd1) ? a : b);
      slot = 12'h300 + 12'(4 * j);
      emit(enc_i(12'd1, 5'd0, 3'b000, 5'd23, OPI));
      emit(enc_b(13'd12, r2, r1, f3));
      emit(enc_i(12'd0, 5'd0, 3'b000, 5'd23, OPI));
      emit(enc_s(slot, 5'd0, 5'd0));
      if (!tk)
        expect_store(slot, 32'h0);
      store_check(5'd23, 12'h140 + 12'(4 * j), {31'b0, tk});
    end
    mark(12'd4);
    // jal over two poison stores
    here = 32'(loc * 4);
    emit(enc_j(21'd12, 5'd25));
    emit(enc_s(12'h330, 5'd0, 5'd0));
    emit(enc_s(12'h334, 5'd0, 5'd0));
    store_check(5'd25, 12'h170, here + 32'd4);
    // jalr to target + 1, bit 0 dropped
    emit(enc_i(12'(loc * 4 + 16), 5'd0, 3'b000, 5'd26, OPI));
    here = 32'(loc * 4);
    emit(enc_i(12'd1, 5'd26, 3'b000, 5'd27, 7'b1100111));
    emit(enc_s(12'h338, 5'd0, 5'd0));
    emit(enc_s(12'h33c, 5'd0, 5'd0));
    store_check(5'd27, 12'h174, here + 32'd4);
    mark(12'd5);
    emit(enc_j(21'd0, 5'd0));
  endtask

  initial
  begin
    clk               = 1'b0;
    reset             = 1'b1;
    error_count       = 0;
    test_start_errors = 0;
    pass_count        = 0;
    fail_count        = 0;
    done_mask         = '0;
    marker_hit        = 1'b0;
    marker_value      = '0;
    loc               = 0;
    missing           = 0;
    lfsr_state        = 32'hdeecdf61;
    test_name = '{"arithmetic", "forwarding", "load-use", "branches", "jumps"};
    for (int i = 0; i < 256; i++)
    begin
      imem[i]      = 32'h0000_0013;
      dmem[i]      = 32'ha5a5_0000 ^ 32'(i * 4);
      exp_valid[i] = 1'b0;
      exp_data[i]  = '0;
      seen[i]      = 1'b0;
    end
    for (int i = 0; i < 5; i++)
    begin
      opnd[i] = lfsr_word();
      dmem[i] = opnd[i];
    end
    build_program();
    repeat (8) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!done_mask[5] && cycles < 3000)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!done_mask[5])
    begin
      for (int t = 5; t >= 1; t--)
        if (!done_mask[t])
          missing = t;
      error_count++;
      $display("timeout: test %0d %s never finished", missing, test_name[missing]);
    end
    else
    begin
      for (int i = 0; i < 256; i++)
      begin
        if (exp_valid[i] && !seen[i])
        begin
          error_count++;
          $display("expected store to %h never happened", 32'(i * 4));
        end
      end
    end
    $display("tests: %0d ok, %0d with errors, %0d errors in total",
             pass_count, fail_count, error_count);
    if (error_count == 0 && fail_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+verif
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_hazard_unit.sv
logic/rv_execute.sv
core/rv32i_core.sv
verif/tb_rv32i_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32i_core
RTL_TOP   ?= rv32i_core
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
